// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= rocc_dma_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== common/rocc_cmd_pkg.sv ====
// rocc command types
package rocc_cmd_pkg;

  typedef logic [6:0] funct_t;
  typedef logic [6:0] opcode_t;

  // architectural register index
  typedef logic [4:0] reg_idx_t;

  typedef logic [31:0] xword_t;

  // setting word carried in rs1 by funct 0
  typedef struct packed {
    logic [30:0] reserved;
    logic        long_burst;
  } setting_t;

  // rs1 is an address for transfers and a setting for funct 0
  typedef union packed {
    xword_t   addr;
    setting_t setting;
  } rs1_view_u;

  typedef enum logic {
    xfer_read  = 1'b0,
    xfer_write = 1'b1
  } xfer_kind_e;

endpackage

// ==== common/rocc_dma_params.svh ====
// rocc dma constants
`ifndef ROCC_DMA_PARAMS_SVH
`define ROCC_DMA_PARAMS_SVH

// custom-0 command decode
`define ROCC_OPCODE   7'h0b
`define FUNCT_SETTING 7'd0
`define FUNCT_READ    7'd1
`define FUNCT_WRITE   7'd3

// burst lengths in words
`define BURST_SHORT   11'd128
`define BURST_LONG    11'd1024

`define TAG_LAST      9'h03f
`define BUF_DEPTH     1024
`define WORD_STEP     32'd4

`endif

// ==== common/rocc_mem_pkg.sv ====
// rocc memory port types
package rocc_mem_pkg;

  typedef logic [31:0] mem_addr_t;
  typedef logic [31:0] mem_word_t;

  // matches the data cache tag width
  typedef logic [8:0] mem_tag_t;

  typedef enum logic [4:0] {
    mem_load  = 5'd0,
    mem_store = 5'd1
  } mem_cmd_e;

  typedef logic [1:0] mem_size_t;

  // local buffer index
  typedef logic [9:0] buf_addr_t;

  // word count, wide enough for 1024
  typedef logic [10:0] burst_len_t;

endpackage

// ==== dma/burst_engine.sv ====
// read and write burst sequencer
`timescale 1ns/100ps
`include "rocc_dma_params.svh"

module burst_engine (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      start,
  input  rocc_cmd_pkg::xfer_kind_e  kind,
  input  rocc_mem_pkg::mem_addr_t   base_addr,
  input  rocc_mem_pkg::burst_len_t  burst_len,
  output logic                      mem_req_valid,
  output rocc_mem_pkg::mem_addr_t   mem_req_addr,
  output rocc_mem_pkg::mem_tag_t    mem_req_tag,
  output rocc_mem_pkg::mem_cmd_e    mem_req_cmd,
  input  logic                      mem_req_ready,
  input  logic                      mem_resp_valid,
  input  rocc_mem_pkg::mem_word_t   mem_resp_data,
  output logic                      buf_we,
  output logic                      buf_re,
  output rocc_mem_pkg::buf_addr_t   buf_addr,
  output rocc_mem_pkg::mem_word_t   buf_wdata,
  output logic                      active,
  output logic                      done
);
  import rocc_cmd_pkg::*;
  import rocc_mem_pkg::*;

  burst_len_t req_cnt;
  burst_len_t resp_cnt;
  logic       preload;
  logic       is_write;
  logic       req_fire;
  logic       resp_fire;
  logic       last_req;
  logic       last_resp;

  assign is_write  = (mem_req_cmd == mem_store);
  assign req_fire  = mem_req_valid && mem_req_ready;
  assign resp_fire = active && !is_write && mem_resp_valid;
  assign last_req  = (req_cnt == burst_len - 11'd1);
  assign last_resp = (resp_cnt == burst_len - 11'd1);

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      active        <= 1'b0;
      done          <= 1'b0;
      preload       <= 1'b0;
      mem_req_valid <= 1'b0;
      mem_req_cmd   <= mem_load;
      mem_req_tag   <= '0;
      req_cnt       <= '0;
      resp_cnt      <= '0;
    end
    else
    begin
      done <= 1'b0;
      if (start)
      begin
        active      <= 1'b1;
        req_cnt     <= '0;
        resp_cnt    <= '0;
        mem_req_tag <= (mem_req_tag == `TAG_LAST) ? '0 : mem_req_tag + 9'd1;
        if (kind == xfer_write)
        begin
          // one cycle to fetch buffer word 0
          mem_req_cmd <= mem_store;
          preload     <= 1'b1;
        end
        else
        begin
          mem_req_cmd   <= mem_load;
          mem_req_valid <= 1'b1;
        end
      end
      if (preload)
      begin
        preload       <= 1'b0;
        mem_req_valid <= 1'b1;
      end
      if (req_fire)
      begin
        req_cnt <= req_cnt + 11'd1;
        if (last_req)
        begin
          mem_req_valid <= 1'b0;
          // stores finish on the last accept
          if (is_write)
          begin
            active <= 1'b0;
            done   <= 1'b1;
          end
        end
      end
      // loads finish on the last in-order response
      if (resp_fire)
      begin
        resp_cnt <= resp_cnt + 11'd1;
        if (last_resp)
        begin
          active <= 1'b0;
          done   <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock)
  begin
    if (start)
      mem_req_addr <= base_addr;
    else if (req_fire)
      mem_req_addr <= mem_req_addr + `WORD_STEP;
  end

  // responses fill the buffer in arrival order
  assign buf_we    = resp_fire;
  assign buf_wdata = mem_resp_data;

  // next store word is fetched on each accept
  assign buf_re = preload || (is_write && req_fire && !last_req);

  always_comb
  begin
    if (!is_write)
      buf_addr = buf_addr_t'(resp_cnt);
    else if (preload)
      buf_addr = '0;
    else
      buf_addr = buf_addr_t'(req_cnt + 11'd1);
  end

endmodule

// ==== dma/cmd_decode.sv ====
// custom command decode
`timescale 1ns/100ps
`include "rocc_dma_params.svh"

module cmd_decode (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      cmd_valid,
  input  rocc_cmd_pkg::funct_t      cmd_funct,
  input  rocc_cmd_pkg::opcode_t     cmd_opcode,
  input  rocc_cmd_pkg::xword_t      cmd_rs1,
  input  logic                      active,
  output logic                      start,
  output rocc_cmd_pkg::xfer_kind_e  kind,
  output rocc_mem_pkg::mem_addr_t   base_addr,
  output rocc_mem_pkg::burst_len_t  burst_len
);
  import rocc_cmd_pkg::*;

  rs1_view_u rs1_view;
  logic      idle;
  logic      ours;
  logic      take_setting;
  logic      take_xfer;
  logic      long_burst;

  assign rs1_view = cmd_rs1;

  // engine counts as busy during the start strobe too
  assign idle = !active && !start;
  assign ours = cmd_valid && (cmd_opcode == `ROCC_OPCODE) && idle;

  assign take_setting = ours && (cmd_funct == `FUNCT_SETTING);
  assign take_xfer = ours && (cmd_funct == `FUNCT_READ || cmd_funct == `FUNCT_WRITE);

  assign burst_len = long_burst ? `BURST_LONG : `BURST_SHORT;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      start      <= 1'b0;
      kind       <= xfer_read;
      long_burst <= 1'b0;
    end
    else
    begin
      start <= take_xfer;
      if (take_setting)
        long_burst <= rs1_view.setting.long_burst;
      if (take_xfer)
        kind <= (cmd_funct == `FUNCT_WRITE) ? xfer_write : xfer_read;
    end
  end

  always_ff @(posedge clock)
  begin
    if (take_xfer)
      base_addr <= rs1_view.addr;
  end

endmodule

// ==== dma/word_buffer.sv ====
// local burst word buffer
`timescale 1ns/100ps
`include "rocc_dma_params.svh"

module word_buffer (
  input  logic                     clock,
  input  logic                     we,
  input  logic                     re,
  input  rocc_mem_pkg::buf_addr_t  addr,
  input  rocc_mem_pkg::mem_word_t  wdata,
  output rocc_mem_pkg::mem_word_t  rdata
);
  import rocc_mem_pkg::*;

  mem_word_t mem [`BUF_DEPTH];

  // single port with registered read
  always_ff @(posedge clock)
  begin
    if (we)
      mem[addr] <= wdata;
    else if (re)
      rdata <= mem[addr];
  end

endmodule

// ==== hw/resp_gen.sv ====
// command response and interrupt
`timescale 1ns/100ps
`include "rocc_dma_params.svh"

module resp_gen (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    cmd_valid,
  input  logic                    cmd_xd,
  input  rocc_cmd_pkg::reg_idx_t  cmd_rd,
  input  rocc_cmd_pkg::funct_t    cmd_funct,
  input  logic                    active,
  input  logic                    done,
  output logic                    resp_valid,
  output rocc_cmd_pkg::reg_idx_t  resp_rd,
  output rocc_cmd_pkg::xword_t    resp_data,
  input  logic                    resp_ready,
  output logic                    interrupt
);
  import rocc_cmd_pkg::*;

  funct_t funct_q;
  logic   active_q;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      resp_valid <= 1'b0;
      interrupt  <= 1'b0;
    end
    else
    begin
      // one cycle pulse per finished transfer
      interrupt <= done;
      if (cmd_valid && cmd_xd)
        resp_valid <= 1'b1;
      else if (resp_ready)
        resp_valid <= 1'b0;
    end
  end

  // a later command with xd replaces the pending one
  always_ff @(posedge clock)
  begin
    if (cmd_valid && cmd_xd)
    begin
      resp_rd  <= cmd_rd;
      funct_q  <= cmd_funct;
      active_q <= active;
    end
  end

  always_comb
  begin
    case (funct_q)
      `FUNCT_SETTING: resp_data = {27'd0, resp_rd};
      `FUNCT_READ,
      `FUNCT_WRITE:   resp_data = {31'd0, active_q};
      default:        resp_data = '0;
    endcase
  end

endmodule

// ==== hw/rocc_dma_top.sv ====
// rocc burst dma top level
`timescale 1ns/100ps

module rocc_dma_top (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     cmd_valid,
  output logic                     cmd_ready,
  input  rocc_cmd_pkg::funct_t     cmd_funct,
  input  rocc_cmd_pkg::opcode_t    cmd_opcode,
  input  rocc_cmd_pkg::reg_idx_t   cmd_rd,
  input  logic                     cmd_xd,
  input  rocc_cmd_pkg::xword_t     cmd_rs1,
  output logic                     resp_valid,
  input  logic                     resp_ready,
  output rocc_cmd_pkg::reg_idx_t   resp_rd,
  output rocc_cmd_pkg::xword_t     resp_data,
  output logic                     mem_req_valid,
  input  logic                     mem_req_ready,
  output rocc_mem_pkg::mem_addr_t  mem_req_addr,
  output rocc_mem_pkg::mem_tag_t   mem_req_tag,
  output rocc_mem_pkg::mem_cmd_e   mem_req_cmd,
  output rocc_mem_pkg::mem_size_t  mem_req_size,
  output rocc_mem_pkg::mem_word_t  mem_req_data,
  input  logic                     mem_resp_valid,
  input  rocc_mem_pkg::mem_word_t  mem_resp_data,
  output logic                     busy,
  output logic                     interrupt
);
  import rocc_cmd_pkg::*;
  import rocc_mem_pkg::*;

  logic       start;
  xfer_kind_e kind;
  mem_addr_t  base_addr;
  burst_len_t burst_len;
  logic       active;
  logic       done;
  logic       buf_we;
  logic       buf_re;
  buf_addr_t  buf_addr;
  mem_word_t  buf_wdata;

  // commands are never back-pressured
  assign cmd_ready = 1'b1;
  // always word sized
  assign mem_req_size = 2'b10;
  assign busy = active;

  cmd_decode u_cmd_decode (
    .clock      (clock),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd_funct  (cmd_funct),
    .cmd_opcode (cmd_opcode),
    .cmd_rs1    (cmd_rs1),
    .active     (active),
    .start      (start),
    .kind       (kind),
    .base_addr  (base_addr),
    .burst_len  (burst_len)
  );

  burst_engine u_burst_engine (
    .clock          (clock),
    .reset          (reset),
    .start          (start),
    .kind           (kind),
    .base_addr      (base_addr),
    .burst_len      (burst_len),
    .mem_req_valid  (mem_req_valid),
    .mem_req_addr   (mem_req_addr),
    .mem_req_tag    (mem_req_tag),
    .mem_req_cmd    (mem_req_cmd),
    .mem_req_ready  (mem_req_ready),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data),
    .buf_we         (buf_we),
    .buf_re         (buf_re),
    .buf_addr       (buf_addr),
    .buf_wdata      (buf_wdata),
    .active         (active),
    .done           (done)
  );

  // buffer read data feeds the store data directly
  word_buffer u_word_buffer (
    .clock (clock),
    .we    (buf_we),
    .re    (buf_re),
    .addr  (buf_addr),
    .wdata (buf_wdata),
    .rdata (mem_req_data)
  );

  resp_gen u_resp_gen (
    .clock      (clock),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd_xd     (cmd_xd),
    .cmd_rd     (cmd_rd),
    .cmd_funct  (cmd_funct),
    .active     (active),
    .done       (done),
    .resp_valid (resp_valid),
    .resp_rd    (resp_rd),
    .resp_data  (resp_data),
    .resp_ready (resp_ready),
    .interrupt  (interrupt)
  );

endmodule

// ==== sources.f ====
+incdir+common
common/rocc_cmd_pkg.sv
common/rocc_mem_pkg.sv
dma/word_buffer.sv
dma/cmd_decode.sv
dma/burst_engine.sv
hw/resp_gen.sv
hw/rocc_dma_top.sv
tests/rocc_dma_checker.sv
tests/rocc_dma_tb.sv

// ==== tests/rocc_dma_checker.sv ====
// burst dma protocol checks
`timescale 1ns/100ps

module rocc_dma_checker (
  input logic                     clock,
  input logic                     reset,
  input logic                     mem_req_valid,
  input logic                     mem_req_ready,
  input rocc_mem_pkg::mem_addr_t  mem_req_addr,
  input rocc_mem_pkg::mem_tag_t   mem_req_tag,
  input rocc_mem_pkg::mem_cmd_e   mem_req_cmd,
  input rocc_mem_pkg::mem_size_t  mem_req_size,
  input rocc_mem_pkg::mem_word_t  mem_req_data,
  input logic                     interrupt,
  input logic                     resp_valid,
  input logic                     resp_ready
);
  int fail_count = 0;

  // request fields hold while memory stalls
  req_hold: assert property (@(posedge clock) disable iff (reset)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr) &&
      $stable(mem_req_tag) && $stable(mem_req_cmd) && $stable(mem_req_size) &&
      $stable(mem_req_data))
  else
  begin
    fail_count++;
    $error("memory request changed while stalled");
  end

  irq_pulse: assert property (@(posedge clock) disable iff (reset)
    interrupt |=> !interrupt)
  else
  begin
    fail_count++;
    $error("interrupt high for two cycles");
  end

  resp_hold: assert property (@(posedge clock) disable iff (reset)
    resp_valid && !resp_ready |=> resp_valid)
  else
  begin
    fail_count++;
    $error("response dropped before ready");
  end

endmodule

bind rocc_dma_top rocc_dma_checker u_rocc_dma_checker (
  .clock         (clock),
  .reset         (reset),
  .mem_req_valid (mem_req_valid),
  .mem_req_ready (mem_req_ready),
  .mem_req_addr  (mem_req_addr),
  .mem_req_tag   (mem_req_tag),
  .mem_req_cmd   (mem_req_cmd),
  .mem_req_size  (mem_req_size),
  .mem_req_data  (mem_req_data),
  .interrupt     (interrupt),
  .resp_valid    (resp_valid),
  .resp_ready    (resp_ready)
);

// ==== tests/rocc_dma_tb.sv ====
// rocc dma testbench
`timescale 1ns/100ps
`include "rocc_dma_params.svh"

module rocc_dma_tb;
  import rocc_cmd_pkg::*;
  import rocc_mem_pkg::*;

  localparam int NUM_ROWS = 10;
  localparam int WAIT_LIMIT = 20000;
  localparam mem_word_t FILL_KEY = 32'h5a3c_c3a5;
  localparam mem_addr_t SRC_A = 32'h0001_0000;
  localparam mem_addr_t DST_B = 32'h0002_0000;
  localparam mem_addr_t SRC_C = 32'h0004_0000;
  localparam mem_addr_t DST_D = 32'h0008_0000;
  // log2 of four bytes
  localparam mem_size_t SIZE_WORD = 2'b10;

  // one command per row
  typedef struct packed {
    funct_t   funct;
    xword_t   rs1;
    reg_idx_t rd;
    logic     xd;
    xword_t   exp_data;
    logic     finish;
  } row_t;

  logic      clock = 1'b0;
  logic      reset;
  logic      cmd_valid;
  logic      cmd_ready;
  funct_t    cmd_funct;
  opcode_t   cmd_opcode;
  reg_idx_t  cmd_rd;
  logic      cmd_xd;
  xword_t    cmd_rs1;
  logic      resp_valid;
  logic      resp_ready;
  reg_idx_t  resp_rd;
  xword_t    resp_data;
  logic      mem_req_valid;
  logic      mem_req_ready = 1'b0;
  mem_addr_t mem_req_addr;
  mem_tag_t  mem_req_tag;
  mem_cmd_e  mem_req_cmd;
  mem_size_t mem_req_size;
  mem_word_t mem_req_data;
  logic      mem_resp_valid = 1'b0;
  mem_word_t mem_resp_data = '0;
  logic      busy;
  logic      interrupt;

  row_t       rows [NUM_ROWS];
  mem_word_t  memory [mem_addr_t];
  mem_word_t  load_q [$];
  mem_addr_t  req_addr_q [$];
  mem_tag_t   req_tag_q [$];
  mem_cmd_e   req_cmd_q [$];
  mem_word_t  req_data_q [$];
  int         seed = 32'hfcb5;
  int         irq_count = 0;
  int         irq_expected;
  int         xfer_len;
  int         i;
  logic       long_mode;
  logic       in_flight;
  logic       starts;
  xfer_kind_e xfer_kind;
  mem_addr_t  xfer_base;
  mem_addr_t  last_read_base;
  mem_tag_t   exp_tag;

  rocc_dma_top u_rocc_dma_top (.*);

  always #20 clock = ~clock;

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    abort_run();
  endtask

  task automatic check_word(input string name, input mem_word_t actual, input mem_word_t expected);
    if (actual !== expected)
    begin
      $display("ERROR %s: got %h, expected %h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_tag(input string name, input mem_tag_t actual, input mem_tag_t expected);
    if (actual !== expected)
    begin
      $display("ERROR %s: got %h, expected %h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_rd(input string name, input reg_idx_t actual, input reg_idx_t expected);
    if (actual !== expected)
    begin
      $display("ERROR %s: got %h, expected %h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_cmd(input string name, input mem_cmd_e actual, input mem_cmd_e expected);
    if (actual !== expected)
    begin
      $display("ERROR %s: got %h, expected %h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_size(input string name, input mem_size_t actual,
                            input mem_size_t expected);
    if (actual !== expected)
    begin
      $display("ERROR %s: got %h, expected %h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
      $display("ERROR %s: got %h, expected %h", name, actual, expected);
      abort_run();
    end
  endtask

  // unwritten words read back as address xor key
  function automatic mem_word_t read_model(input mem_addr_t addr);
    if (memory.exists(addr))
      return memory[addr];
    return addr ^ FILL_KEY;
  endfunction

  function automatic row_t make_row(input funct_t funct, input xword_t rs1, input reg_idx_t rd,
                                    input logic xd, input xword_t exp_data, input logic finish);
    row_t r;
    r.funct = funct;
    r.rs1 = rs1;
    r.rd = rd;
    r.xd = xd;
    r.exp_data = exp_data;
    r.finish = finish;
    return r;
  endfunction

  // status rows run while the previous transfer is still active
  task automatic fill_table();
    rows[0] = make_row(`FUNCT_SETTING, 32'd0, 5'd5, 1'b1, 32'd5, 1'b0);
    rows[1] = make_row(`FUNCT_READ, SRC_A, 5'd1, 1'b1, 32'd0, 1'b0);
    rows[2] = make_row(`FUNCT_READ, DST_D, 5'd2, 1'b1, 32'd1, 1'b1);
    rows[3] = make_row(`FUNCT_WRITE, DST_B, 5'd3, 1'b1, 32'd0, 1'b1);
    rows[4] = make_row(`FUNCT_SETTING, 32'd1, 5'd7, 1'b1, 32'd7, 1'b0);
    rows[5] = make_row(`FUNCT_READ, SRC_C, 5'd8, 1'b0, 32'd0, 1'b1);
    rows[6] = make_row(`FUNCT_WRITE, DST_D, 5'd10, 1'b1, 32'd0, 1'b0);
    rows[7] = make_row(`FUNCT_WRITE, SRC_A, 5'd11, 1'b1, 32'd1, 1'b1);
    rows[8] = make_row(7'd5, 32'd0, 5'd9, 1'b1, 32'd0, 1'b0);
    rows[9] = make_row(`FUNCT_SETTING, 32'd0, 5'd4, 1'b1, 32'd4, 1'b0);
  endtask

  task automatic send_command(input row_t r);
    cmd_valid = 1'b1;
    cmd_opcode = `ROCC_OPCODE;
    cmd_funct = r.funct;
    cmd_rs1 = r.rs1;
    cmd_rd = r.rd;
    cmd_xd = r.xd;
    check_bit("cmd_ready", cmd_ready, 1'b1);
    @(posedge clock);
    #1;
    cmd_valid = 1'b0;
    cmd_xd = 1'b0;
  endtask

  task automatic wait_response(input reg_idx_t rd, input xword_t data);
    int n;
    for (n = 0; n < 16 && !resp_valid; n++)
    begin
      @(posedge clock);
      #1;
    end
    if (!resp_valid)
      report_failure("timeout waiting for the command response");
    check_rd("resp_rd", resp_rd, rd);
    check_word("resp_data", resp_data, data);
    // response waits for ready, then leaves
    @(posedge clock);
    #1;
    check_bit("resp_valid", resp_valid, 1'b1);
    check_rd("resp_rd", resp_rd, rd);
    resp_ready = 1'b1;
    @(posedge clock);
    #1;
    resp_ready = 1'b0;
    check_bit("resp_valid", resp_valid, 1'b0);
  endtask

  task automatic wait_busy();
    int n;
    for (n = 0; n < 16 && !busy; n++)
    begin
      @(posedge clock);
      #1;
    end
    if (!busy)
      report_failure("busy did not rise after the transfer command");
  endtask

  // busy may be low only in the cycle just before the interrupt
  task automatic wait_interrupt();
    int n;
    int low;
    low = 0;
    for (n = 0; n < WAIT_LIMIT && !interrupt; n++)
    begin
      if (!busy)
        low++;
      if (low > 1)
        report_failure("busy fell more than one cycle before the interrupt");
      @(posedge clock);
      #1;
    end
    if (!interrupt)
      report_failure("timeout waiting for the transfer interrupt");
    check_bit("busy", busy, 1'b0);
  endtask

  task automatic finish_transfer();
    int k;
    mem_word_t expected;
    wait_interrupt();
    irq_expected++;
    @(posedge clock);
    #1;
    if (irq_count != irq_expected)
      report_failure("interrupt count does not match the finished transfers");
    if (req_addr_q.size() != xfer_len)
      report_failure("wrong number of memory requests in the burst");
    if (load_q.size() != 0)
      report_failure("memory responses left over after the transfer");
    for (k = 0; k < xfer_len; k++)
    begin
      check_word("mem_req_addr", req_addr_q[k], xfer_base + mem_addr_t'(k) * `WORD_STEP);
      check_tag("mem_req_tag", req_tag_q[k], exp_tag);
      if (xfer_kind == xfer_write)
      begin
        check_cmd("mem_req_cmd", req_cmd_q[k], mem_store);
        expected = read_model(last_read_base + mem_addr_t'(k) * `WORD_STEP);
        check_word("mem_req_data", req_data_q[k], expected);
      end
      else
        check_cmd("mem_req_cmd", req_cmd_q[k], mem_load);
    end
    if (xfer_kind == xfer_read)
      last_read_base = xfer_base;
    in_flight = 1'b0;
    req_addr_q.delete();
    req_tag_q.delete();
    req_cmd_q.delete();
    req_data_q.delete();
  endtask

  // memory model with random ready and in-order load responses
  always @(posedge clock)
  begin
    if (!reset && mem_req_valid && mem_req_ready)
    begin
      check_size("mem_req_size", mem_req_size, SIZE_WORD);
      req_addr_q.push_back(mem_req_addr);
      req_tag_q.push_back(mem_req_tag);
      req_cmd_q.push_back(mem_req_cmd);
      req_data_q.push_back(mem_req_data);
      if (mem_req_cmd == mem_store)
        memory[mem_req_addr] = mem_req_data;
      else
        load_q.push_back(read_model(mem_req_addr));
    end
    if (!reset && interrupt)
      irq_count++;
    #1;
    mem_req_ready = ($random(seed) & 3) != 0;
    if (load_q.size() > 0)
    begin
      mem_resp_valid = 1'b1;
      mem_resp_data = load_q.pop_front();
    end
    else
    begin
      mem_resp_valid = 1'b0;
      mem_resp_data = '0;
    end
  end

  always @(negedge clock)
  begin
    if (u_rocc_dma_top.u_rocc_dma_checker.fail_count != 0)
      report_failure("protocol assertion failed");
  end

  initial
  begin
    reset = 1'b1;
    cmd_valid = 1'b0;
    cmd_funct = '0;
    cmd_opcode = '0;
    cmd_rd = '0;
    cmd_xd = 1'b0;
    cmd_rs1 = '0;
    resp_ready = 1'b0;
    long_mode = 1'b0;
    in_flight = 1'b0;
    exp_tag = '0;
    irq_expected = 0;
    xfer_len = 0;
    xfer_kind = xfer_read;
    xfer_base = '0;
    last_read_base = SRC_A;
    fill_table();
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    check_bit("mem_req_valid", mem_req_valid, 1'b0);
    check_bit("resp_valid", resp_valid, 1'b0);
    check_bit("interrupt", interrupt, 1'b0);
    check_bit("busy", busy, 1'b0);
    for (i = 0; i < NUM_ROWS; i++)
    begin
      starts = (rows[i].funct == `FUNCT_READ || rows[i].funct == `FUNCT_WRITE) && !in_flight;
      if (starts)
      begin
        xfer_kind = (rows[i].funct == `FUNCT_WRITE) ? xfer_write : xfer_read;
        xfer_base = rows[i].rs1;
        xfer_len = long_mode ? int'(`BURST_LONG) : int'(`BURST_SHORT);
        exp_tag = (exp_tag == `TAG_LAST) ? '0 : exp_tag + 9'd1;
      end
      if (rows[i].funct == `FUNCT_SETTING && !in_flight)
        long_mode = rows[i].rs1[0];
      send_command(rows[i]);
      if (rows[i].xd)
        wait_response(rows[i].rd, rows[i].exp_data);
      else
        check_bit("resp_valid", resp_valid, 1'b0);
      if (starts)
      begin
        wait_busy();
        in_flight = 1'b1;
      end
      if (rows[i].finish)
        finish_transfer();
    end
    if (u_rocc_dma_top.u_rocc_dma_checker.fail_count == 0)
    begin
      $display("=== PASS ===");
      $finish;
    end
    else
    begin
      report_failure("protocol checker reported assertion failures");
    end
  end

endmodule
